// File: logic/fe_decode_defs.svh
`ifndef FE_DECODE_DEFS_SVH
`define FE_DECODE_DEFS_SVH

// Bundle geometry
`define FE_LANES        4
`define FE_INSTR_W      32
`define FE_PC_W         32
`define FE_QUEUE_DEPTH  2

// RV32 major opcodes
`define FE_OPC_LUI      7'b0110111
`define FE_OPC_AUIPC    7'b0010111
`define FE_OPC_OPIMM    7'b0010011
`define FE_OPC_OP       7'b0110011
`define FE_OPC_LOAD     7'b0000011
`define FE_OPC_STORE    7'b0100011
`define FE_OPC_BRANCH   7'b1100011
`define FE_OPC_JAL      7'b1101111
`define FE_OPC_JALR     7'b1100111
`define FE_OPC_SYSTEM   7'b1110011

// funct7 of the M extension
`define FE_F7_MULDIV    7'b0000001

`endif

// File: logic/fe_decode_pkg.sv
`include "fe_decode_defs.svh"

package fe_decode_pkg;

    //------------------------------------------------------------
    // Per-lane classification
    //------------------------------------------------------------
    // Flag order is also the bit order of the top level info bus
    typedef struct packed {
        logic invalid;
        logic exec;
        logic lsu;
        logic branch;
        logic mul;
        logic div;
        logic csr;
        logic rd_valid;
        logic fault_fetch;
        logic fault_page;
    } lane_info_t;

    //------------------------------------------------------------
    // Raw bundle as delivered by fetch
    //------------------------------------------------------------
    typedef struct packed {
        logic [`FE_PC_W-1:0]                     pc;
        // Number of valid lanes minus one
        logic [$clog2(`FE_LANES)-1:0]            count;
        logic [`FE_LANES-1:0][`FE_INSTR_W-1:0]   instr;
        logic                                    fault_fetch;
        logic                                    fault_page;
    } fetch_bundle_t;

    //------------------------------------------------------------
    // Bundle after decode
    //------------------------------------------------------------
    typedef struct packed {
        logic [`FE_PC_W-1:0]                     pc;
        logic [`FE_LANES-1:0][`FE_INSTR_W-1:0]   instr;
        logic [`FE_LANES-1:0]                    lane_valid;
        lane_info_t [`FE_LANES-1:0]              info;
    } decoded_bundle_t;

endpackage

// File: logic/bundle_if.sv
`timescale 1ns/1ns

// One bundle between two pipeline stages, valid/accept handshake
interface bundle_if #(
    parameter type payload_t = logic
);
    logic     valid;
    logic     accept;
    payload_t data;
    // Branch flush, common to all stages
    logic     flush;

    modport src (output valid, output data, input accept, input flush);
    modport dst (input valid, input data, output accept, input flush);

endinterface

// File: logic/fetch_capture.sv
`timescale 1ns/1ns

module fetch_capture (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          fetch_valid_i,
    input  fe_decode_pkg::fetch_bundle_t  fetch_bundle_i,
    output logic                          fetch_accept_o,
    bundle_if.src                         out
);

    logic                          valid_q;
    fe_decode_pkg::fetch_bundle_t  bundle_q;
    fe_decode_pkg::fetch_bundle_t  capture_w;
    logic                          fault_w;

    // Take a new bundle when empty or when the holder moves on
    assign fetch_accept_o = !valid_q || out.accept;

    // Faulted fetch carries no usable instruction words
    assign fault_w = fetch_bundle_i.fault_fetch | fetch_bundle_i.fault_page;

    always_comb
    begin
        capture_w = fetch_bundle_i;
        if (fault_w)
            capture_w.instr = '0;
    end

    //------------------------------------------------------------
    // Stage register
    //------------------------------------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            valid_q <= 1'b0;
        else if (out.flush)
            valid_q <= 1'b0;
        else if (fetch_accept_o)
            valid_q <= fetch_valid_i;
    end

    always_ff @(posedge clk_i)
    begin
        if (fetch_accept_o && fetch_valid_i)
            bundle_q <= capture_w;
    end

    assign out.valid = valid_q;
    assign out.data  = bundle_q;

endmodule

// File: logic/lane_decoder.sv
`timescale 1ns/1ns

`include "fe_decode_defs.svh"

module lane_decoder (
    input  logic [`FE_INSTR_W-1:0]     instr_i,
    input  logic                       fault_fetch_i,
    input  logic                       fault_page_i,
    output fe_decode_pkg::lane_info_t  info_o
);

    logic [6:0] opcode_w;
    logic [2:0] funct3_w;
    logic [6:0] funct7_w;
    logic       rd_nz_w;

    // RV32 base instruction fields
    assign opcode_w = instr_i[6:0];
    assign funct3_w = instr_i[14:12];
    assign funct7_w = instr_i[31:25];
    assign rd_nz_w  = (instr_i[11:7] != 5'd0);

    always_comb
    begin
        info_o             = '0;
        info_o.fault_fetch = fault_fetch_i;
        info_o.fault_page  = fault_page_i;

        // Faulted lanes only report their fault
        if (!(fault_fetch_i || fault_page_i))
        begin
            case (opcode_w)
                `FE_OPC_LUI, `FE_OPC_AUIPC, `FE_OPC_OPIMM:
                begin
                    info_o.exec     = 1'b1;
                    info_o.rd_valid = rd_nz_w;
                end
                `FE_OPC_OP:
                begin
                    if (funct7_w == 7'b0000000 || funct7_w == 7'b0100000)
                    begin
                        info_o.exec     = 1'b1;
                        info_o.rd_valid = rd_nz_w;
                    end
                    else if (funct7_w == `FE_F7_MULDIV)
                    begin
                        // mul, mulh, mulhsu, mulhu below div/rem
                        info_o.mul      = !funct3_w[2];
                        info_o.div      = funct3_w[2];
                        info_o.rd_valid = rd_nz_w;
                    end
                    else
                        info_o.invalid  = 1'b1;
                end
                `FE_OPC_LOAD:
                begin
                    info_o.lsu      = 1'b1;
                    info_o.rd_valid = rd_nz_w;
                end
                `FE_OPC_STORE:
                    info_o.lsu = 1'b1;
                `FE_OPC_BRANCH:
                    info_o.branch = 1'b1;
                `FE_OPC_JAL, `FE_OPC_JALR:
                begin
                    info_o.branch   = 1'b1;
                    info_o.rd_valid = rd_nz_w;
                end
                `FE_OPC_SYSTEM:
                begin
                    // ecall/ebreak/mret have funct3 of zero and no rd
                    info_o.csr      = 1'b1;
                    info_o.rd_valid = rd_nz_w && (funct3_w != 3'd0);
                end
                default:
                    info_o.invalid = 1'b1;
            endcase
        end
    end

endmodule

// File: logic/bundle_decode.sv
`timescale 1ns/1ns

module bundle_decode (
    input  logic  clk_i,
    input  logic  rst_i,
    bundle_if.dst in,
    bundle_if.src out
);

    fe_decode_pkg::fetch_bundle_t    raw_w;
    fe_decode_pkg::decoded_bundle_t  dec_w;
    fe_decode_pkg::decoded_bundle_t  dec_q;
    logic                            valid_q;

    assign raw_w     = in.data;
    assign in.accept = !valid_q || out.accept;

    assign dec_w.pc    = raw_w.pc;
    assign dec_w.instr = raw_w.instr;

    // Lane k present when count >= k
    for (genvar k = 0; k < 4; k++)
    begin : g_lane_valid
        assign dec_w.lane_valid[k] = (raw_w.count >= 2'(k));
    end

    //------------------------------------------------------------
    // Lane decoders
    //------------------------------------------------------------
    lane_decoder u_lane0 (
        .instr_i       (raw_w.instr[0]),
        .fault_fetch_i (raw_w.fault_fetch),
        .fault_page_i  (raw_w.fault_page),
        .info_o        (dec_w.info[0])
    );

    lane_decoder u_lane1 (
        .instr_i       (raw_w.instr[1]),
        .fault_fetch_i (raw_w.fault_fetch),
        .fault_page_i  (raw_w.fault_page),
        .info_o        (dec_w.info[1])
    );

    lane_decoder u_lane2 (
        .instr_i       (raw_w.instr[2]),
        .fault_fetch_i (raw_w.fault_fetch),
        .fault_page_i  (raw_w.fault_page),
        .info_o        (dec_w.info[2])
    );

    lane_decoder u_lane3 (
        .instr_i       (raw_w.instr[3]),
        .fault_fetch_i (raw_w.fault_fetch),
        .fault_page_i  (raw_w.fault_page),
        .info_o        (dec_w.info[3])
    );

    //------------------------------------------------------------
    // Stage register
    //------------------------------------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
            valid_q <= 1'b0;
        else if (in.flush)
            valid_q <= 1'b0;
        else if (in.accept)
            valid_q <= in.valid;
    end

    always_ff @(posedge clk_i)
    begin
        if (in.accept && in.valid)
            dec_q <= dec_w;
    end

    assign out.valid = valid_q;
    assign out.data  = dec_q;

endmodule

// File: logic/issue_queue.sv
`timescale 1ns/1ns

`include "fe_decode_defs.svh"

module issue_queue (
    input  logic                                     clk_i,
    input  logic                                     rst_i,
    input  logic [`FE_LANES-1:0]                     lane_accept_i,
    bundle_if.dst                                    in,
    output logic [`FE_LANES-1:0]                     lane_valid_o,
    output logic [`FE_LANES-1:0][`FE_PC_W-1:0]       lane_pc_o,
    output logic [`FE_LANES-1:0][`FE_INSTR_W-1:0]    lane_instr_o,
    output fe_decode_pkg::lane_info_t [`FE_LANES-1:0] lane_info_o
);

    localparam int DEPTH = `FE_QUEUE_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    //------------------------------------------------------------
    // Storage
    //------------------------------------------------------------
    fe_decode_pkg::decoded_bundle_t  mem_q [DEPTH];
    // Lanes of each entry still waiting to be taken
    logic [`FE_LANES-1:0]            left_q [DEPTH];
    logic [PTR_W-1:0]                rd_ptr_q;
    logic [PTR_W-1:0]                wr_ptr_q;
    logic [CNT_W-1:0]                count_q;

    fe_decode_pkg::decoded_bundle_t  in_w;
    fe_decode_pkg::decoded_bundle_t  head_w;
    logic                            push_w;
    logic                            pop_w;
    logic [`FE_LANES-1:0]            take_w;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1))
            return '0;
        return ptr + 1'b1;
    endfunction

    assign in_w      = in.data;
    assign head_w    = mem_q[rd_ptr_q];
    assign in.accept = (count_q < CNT_W'(DEPTH));
    assign push_w    = in.valid && in.accept;

    assign lane_valid_o = (count_q != '0) ? left_q[rd_ptr_q] : '0;
    assign take_w       = lane_accept_i & lane_valid_o;

    // Head retires once nothing valid is left after this edge
    assign pop_w = (count_q != '0) && ((take_w | ~lane_valid_o) == '1);

    //------------------------------------------------------------
    // Control
    //------------------------------------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
            for (int i = 0; i < DEPTH; i++)
                left_q[i] <= '0;
        end
        else if (in.flush)
        begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
            for (int i = 0; i < DEPTH; i++)
                left_q[i] <= '0;
        end
        else
        begin
            if (push_w)
            begin
                left_q[wr_ptr_q] <= in_w.lane_valid;
                wr_ptr_q         <= next_ptr(wr_ptr_q);
            end

            // Never the write slot, the queue is not full on a push
            for (int k = 0; k < `FE_LANES; k++)
            begin
                if (take_w[k])
                    left_q[rd_ptr_q][k] <= 1'b0;
            end

            if (pop_w)
                rd_ptr_q <= next_ptr(rd_ptr_q);

            case ({push_w, pop_w})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (push_w)
            mem_q[wr_ptr_q] <= in_w;
    end

    //------------------------------------------------------------
    // Lane outputs
    //------------------------------------------------------------
    always_comb
    begin
        for (int k = 0; k < `FE_LANES; k++)
        begin
            // Bundle is 16-byte aligned, lane offset in the low bits
            lane_pc_o[k] = {head_w.pc[`FE_PC_W-1:4], 4'(4 * k)};
        end
    end

    assign lane_instr_o = head_w.instr;
    assign lane_info_o  = head_w.info;

endmodule

// File: logic/fe_decode.sv
`timescale 1ns/1ns

`include "fe_decode_defs.svh"

module fe_decode (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             fetch_valid_i,
    input  logic [`FE_PC_W-1:0]              fetch_pc_i,
    input  logic [`FE_LANES*`FE_INSTR_W-1:0] fetch_instr_i,
    input  logic [$clog2(`FE_LANES)-1:0]     fetch_count_i,
    input  logic                             fetch_fault_fetch_i,
    input  logic                             fetch_fault_page_i,
    input  logic                             branch_request_i,
    input  logic [`FE_LANES-1:0]             lane_accept_i,
    output logic                             fetch_accept_o,
    output logic [`FE_LANES-1:0]             lane_valid_o,
    output logic [`FE_LANES*`FE_PC_W-1:0]    lane_pc_o,
    output logic [`FE_LANES*`FE_INSTR_W-1:0] lane_instr_o,
    output logic [`FE_LANES*10-1:0]          lane_info_o
);

    fe_decode_pkg::fetch_bundle_t                fetch_bundle_w;
    logic [`FE_LANES-1:0][`FE_PC_W-1:0]          lane_pc_w;
    logic [`FE_LANES-1:0][`FE_INSTR_W-1:0]       lane_instr_w;
    fe_decode_pkg::lane_info_t [`FE_LANES-1:0]   lane_info_w;

    bundle_if #(.payload_t(fe_decode_pkg::fetch_bundle_t))   raw_if ();
    bundle_if #(.payload_t(fe_decode_pkg::decoded_bundle_t)) dec_if ();

    // Branch redirect empties every stage
    assign raw_if.flush = branch_request_i;
    assign dec_if.flush = branch_request_i;

    //------------------------------------------------------------
    // Fetch side
    //------------------------------------------------------------
    assign fetch_bundle_w.pc          = fetch_pc_i;
    assign fetch_bundle_w.count       = fetch_count_i;
    assign fetch_bundle_w.instr       = fetch_instr_i;
    assign fetch_bundle_w.fault_fetch = fetch_fault_fetch_i;
    assign fetch_bundle_w.fault_page  = fetch_fault_page_i;

    fetch_capture u_capture (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .fetch_valid_i  (fetch_valid_i),
        .fetch_bundle_i (fetch_bundle_w),
        .fetch_accept_o (fetch_accept_o),
        .out            (raw_if)
    );

    bundle_decode u_decode (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .in    (raw_if),
        .out   (dec_if)
    );

    issue_queue u_queue (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .lane_accept_i (lane_accept_i),
        .in            (dec_if),
        .lane_valid_o  (lane_valid_o),
        .lane_pc_o     (lane_pc_w),
        .lane_instr_o  (lane_instr_w),
        .lane_info_o   (lane_info_w)
    );

    // Lane 0 in the low bits of each flat bus
    assign lane_pc_o    = lane_pc_w;
    assign lane_instr_o = lane_instr_w;
    assign lane_info_o  = lane_info_w;

endmodule

// File: dv/fe_decode_model.svh
`ifndef FE_DECODE_MODEL_SVH
`define FE_DECODE_MODEL_SVH

// Bundles accepted at the fetch port and not yet fully issued, oldest first
fe_decode_pkg::fetch_bundle_t exp_q[$];
// Lanes of the oldest bundle still to be taken
logic [`FE_LANES-1:0]         head_left;

function automatic logic [`FE_LANES-1:0] lanes_of_count(input logic [1:0] count);
    logic [`FE_LANES-1:0] mask;
    mask = '0;
    for (int k = 0; k <= count; k++)
        mask[k] = 1'b1;
    return mask;
endfunction

// Bundle is 16-byte aligned, lane k sits at offset 4*k
function automatic logic [31:0] lane_pc_of(input logic [31:0] pc, input int k);
    return (pc & 32'hffff_fff0) | 32'(k * 4);
endfunction

function automatic fe_decode_pkg::lane_info_t classify_instr(
    input logic [31:0] instr,
    input logic        fault_fetch,
    input logic        fault_page
);
    fe_decode_pkg::lane_info_t info;
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       op_alu;
    logic       op_md;
    logic       writes_rd;
    opc    = instr[6:0];
    f3     = instr[14:12];
    f7     = instr[31:25];
    op_alu = (opc == `FE_OPC_OP) && (f7 == 7'h00 || f7 == 7'h20);
    op_md  = (opc == `FE_OPC_OP) && (f7 == `FE_F7_MULDIV);
    info   = '0;
    info.fault_fetch = fault_fetch;
    info.fault_page  = fault_page;
    if (fault_fetch || fault_page)
        return info;
    info.exec   = (opc == `FE_OPC_LUI) || (opc == `FE_OPC_AUIPC) ||
                  (opc == `FE_OPC_OPIMM) || op_alu;
    info.mul    = op_md && (f3 < 3'd4);
    info.div    = op_md && (f3 >= 3'd4);
    info.lsu    = (opc == `FE_OPC_LOAD) || (opc == `FE_OPC_STORE);
    info.branch = (opc == `FE_OPC_BRANCH) || (opc == `FE_OPC_JAL) || (opc == `FE_OPC_JALR);
    info.csr    = (opc == `FE_OPC_SYSTEM);
    info.invalid = !(info.exec || info.mul || info.div || info.lsu || info.branch || info.csr);
    writes_rd = info.exec || op_md || (opc == `FE_OPC_LOAD) || (opc == `FE_OPC_JAL) ||
                (opc == `FE_OPC_JALR) || ((opc == `FE_OPC_SYSTEM) && (f3 != 3'd0));
    info.rd_valid = writes_rd && (instr[11:7] != 5'd0);
    return info;
endfunction

// Faulted fetch arrives with all words cleared
function automatic fe_decode_pkg::fetch_bundle_t captured_bundle(
    input fe_decode_pkg::fetch_bundle_t raw
);
    fe_decode_pkg::fetch_bundle_t b;
    b = raw;
    if (raw.fault_fetch || raw.fault_page)
        b.instr = '0;
    return b;
endfunction

task automatic expect_bundle(input fe_decode_pkg::fetch_bundle_t raw);
    exp_q.push_back(captured_bundle(raw));
    if (exp_q.size() == 1)
        head_left = lanes_of_count(raw.count);
endtask

task automatic drop_expected();
    exp_q.delete();
    head_left = '0;
endtask

task automatic retire_lanes(input logic [`FE_LANES-1:0] taken);
    head_left = head_left & ~taken;
    if (head_left == '0 && exp_q.size() != 0)
    begin
        void'(exp_q.pop_front());
        if (exp_q.size() != 0)
            head_left = lanes_of_count(exp_q[0].count);
    end
endtask

`endif

// File: dv/fe_decode_tb.sv
`timescale 1ns/1ns

`include "fe_decode_defs.svh"

module fe_decode_tb;

    localparam int NUM_CYCLES  = 3000;
    localparam int DRAIN_LIMIT = 200;
    localparam int STALL_LIMIT = 12;

    logic         clk_i;
    logic         rst_i;
    logic         fetch_valid_i;
    logic [31:0]  fetch_pc_i;
    logic [127:0] fetch_instr_i;
    logic [1:0]   fetch_count_i;
    logic         fetch_fault_fetch_i;
    logic         fetch_fault_page_i;
    logic         branch_request_i;
    logic [3:0]   lane_accept_i;
    logic         fetch_accept_o;
    logic [3:0]   lane_valid_o;
    logic [127:0] lane_pc_o;
    logic [127:0] lane_instr_o;
    logic [39:0]  lane_info_o;

    integer seed;
    int     errors;
    int     lanes_checked;
    int     bundles_in;
    int     flushes;
    int     stall_cycles;
    int     waited;
    logic   offer_held;

    `include "fe_decode_model.svh"

    fe_decode dut0 (
        .clk_i               (clk_i),
        .rst_i               (rst_i),
        .fetch_valid_i       (fetch_valid_i),
        .fetch_pc_i          (fetch_pc_i),
        .fetch_instr_i       (fetch_instr_i),
        .fetch_count_i       (fetch_count_i),
        .fetch_fault_fetch_i (fetch_fault_fetch_i),
        .fetch_fault_page_i  (fetch_fault_page_i),
        .branch_request_i    (branch_request_i),
        .lane_accept_i       (lane_accept_i),
        .fetch_accept_o      (fetch_accept_o),
        .lane_valid_o        (lane_valid_o),
        .lane_pc_o           (lane_pc_o),
        .lane_instr_o        (lane_instr_o),
        .lane_info_o         (lane_info_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    //------------------------------------------------------------
    // Stimulus
    //------------------------------------------------------------
    // Weighted mix of legal, mul/div and illegal encodings
    function automatic logic [31:0] random_instr();
        logic [31:0] instr;
        int          pick;
        instr = $random(seed);
        pick  = {$random(seed)} % 16;
        case (pick)
            0, 1:   instr[6:0] = `FE_OPC_LUI;
            2:      instr[6:0] = `FE_OPC_AUIPC;
            3, 4:   instr[6:0] = `FE_OPC_OPIMM;
            5:
            begin
                instr[6:0]   = `FE_OPC_OP;
                instr[31:25] = instr[31] ? 7'b0100000 : 7'b0000000;
            end
            6, 7:
            begin
                instr[6:0]   = `FE_OPC_OP;
                instr[31:25] = `FE_F7_MULDIV;
            end
            8:      instr[6:0] = `FE_OPC_LOAD;
            9:      instr[6:0] = `FE_OPC_STORE;
            10:     instr[6:0] = `FE_OPC_BRANCH;
            11:     instr[6:0] = `FE_OPC_JAL;
            12:     instr[6:0] = `FE_OPC_JALR;
            13:     instr[6:0] = `FE_OPC_SYSTEM;
            14:     instr[6:0] = `FE_OPC_OP;
            default: ;
        endcase
        // Some writes to x0
        if ({$random(seed)} % 4 == 0)
            instr[11:7] = 5'd0;
        return instr;
    endfunction

    task automatic drive_random_inputs(input int cycle);
        // A pending offer stays put until it is taken
        if (!offer_held)
        begin
            fetch_valid_i       = ({$random(seed)} % 4) != 0;
            fetch_pc_i          = $random(seed);
            fetch_count_i       = 2'($random(seed));
            fetch_fault_fetch_i = ({$random(seed)} % 8) == 0;
            fetch_fault_page_i  = ({$random(seed)} % 8) == 0;
            for (int k = 0; k < `FE_LANES; k++)
                fetch_instr_i[k*32 +: 32] = random_instr();
        end
        branch_request_i = ({$random(seed)} % 64) == 0;
        case ((cycle / 200) % 3)
            0:       lane_accept_i = 4'($random(seed));
            // Sparse accepts so the queue fills up
            1:       lane_accept_i = 4'($random(seed) & $random(seed) & $random(seed));
            default: lane_accept_i = 4'hf;
        endcase
    endtask

    //------------------------------------------------------------
    // Scoreboard, run at the falling edge for the coming rising edge
    //------------------------------------------------------------
    task automatic score_edge();
        logic [3:0]                   taken;
        fe_decode_pkg::fetch_bundle_t head;
        fe_decode_pkg::fetch_bundle_t raw;
        fe_decode_pkg::lane_info_t    exp_info;
        fe_decode_pkg::lane_info_t    act_info;
        logic [31:0]                  exp_pc;
        taken = lane_valid_o & lane_accept_i;
        // Queue has room while fewer bundles are in flight than it holds
        if (exp_q.size() < `FE_QUEUE_DEPTH && fetch_accept_o !== 1'b1)
        begin
            $display("[FAIL] %0t fetch_accept_o expected %b actual %b",
                     $time, 1'b1, fetch_accept_o);
            errors++;
        end
        // Both register stages and every queue entry occupied
        if (exp_q.size() >= `FE_QUEUE_DEPTH + 2 && fetch_accept_o !== 1'b0)
        begin
            $display("[FAIL] %0t fetch_accept_o expected %b actual %b",
                     $time, 1'b0, fetch_accept_o);
            errors++;
        end
        if (lane_valid_o !== 4'b0)
        begin
            if (exp_q.size() == 0)
            begin
                $display("[FAIL] %0t lane_valid_o expected %b actual %b",
                         $time, 4'b0, lane_valid_o);
                errors++;
            end
            else if (lane_valid_o !== head_left)
            begin
                $display("[FAIL] %0t lane_valid_o expected %b actual %b",
                         $time, head_left, lane_valid_o);
                errors++;
            end
        end
        if (taken != 4'b0 && exp_q.size() != 0)
        begin
            head = exp_q[0];
            for (int k = 0; k < `FE_LANES; k++)
            begin
                if (taken[k] && head_left[k])
                begin
                    exp_pc   = lane_pc_of(head.pc, k);
                    exp_info = classify_instr(head.instr[k], head.fault_fetch,
                                              head.fault_page);
                    act_info = lane_info_o[k*10 +: 10];
                    if (lane_instr_o[k*32 +: 32] !== head.instr[k])
                    begin
                        $display("[FAIL] %0t lane_instr_o[%0d] expected %h actual %h",
                                 $time, k, head.instr[k], lane_instr_o[k*32 +: 32]);
                        errors++;
                    end
                    if (lane_pc_o[k*32 +: 32] !== exp_pc)
                    begin
                        $display("[FAIL] %0t lane_pc_o[%0d] expected %h actual %h",
                                 $time, k, exp_pc, lane_pc_o[k*32 +: 32]);
                        errors++;
                    end
                    if (act_info !== exp_info)
                    begin
                        $display("[FAIL] %0t lane_info_o[%0d] expected %b actual %b",
                                 $time, k, exp_info, act_info);
                        errors++;
                    end
                    lanes_checked++;
                end
            end
            retire_lanes(taken);
        end
        raw.pc          = fetch_pc_i;
        raw.count       = fetch_count_i;
        raw.instr       = fetch_instr_i;
        raw.fault_fetch = fetch_fault_fetch_i;
        raw.fault_page  = fetch_fault_page_i;
        if (branch_request_i)
        begin
            drop_expected();
            flushes++;
        end
        else if (fetch_valid_i && fetch_accept_o)
        begin
            expect_bundle(raw);
            bundles_in++;
        end
        offer_held = fetch_valid_i && !fetch_accept_o && !branch_request_i;
    endtask

    //------------------------------------------------------------
    // Main sequence
    //------------------------------------------------------------
    initial
    begin
        seed          = 32'hfa1b;
        errors        = 0;
        lanes_checked = 0;
        bundles_in    = 0;
        flushes       = 0;
        stall_cycles  = 0;
        offer_held    = 1'b0;
        head_left     = '0;

        rst_i               = 1'b1;
        fetch_valid_i       = 1'b0;
        fetch_pc_i          = '0;
        fetch_instr_i       = '0;
        fetch_count_i       = '0;
        fetch_fault_fetch_i = 1'b0;
        fetch_fault_page_i  = 1'b0;
        branch_request_i    = 1'b0;
        lane_accept_i       = '0;

        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        if (lane_valid_o !== 4'b0)
        begin
            $display("[FAIL] %0t lane_valid_o expected %b actual %b", $time, 4'b0, lane_valid_o);
            errors++;
        end
        if (fetch_accept_o !== 1'b1)
        begin
            $display("[FAIL] %0t fetch_accept_o expected %b actual %b",
                     $time, 1'b1, fetch_accept_o);
            errors++;
        end

        for (int cycle = 0; cycle < NUM_CYCLES; cycle++)
        begin
            drive_random_inputs(cycle);
            score_edge();
            // Head of the model must reach the lanes within a few cycles
            if (exp_q.size() != 0 && lane_valid_o == 4'b0)
                stall_cycles++;
            else
                stall_cycles = 0;
            if (stall_cycles == STALL_LIMIT)
            begin
                $display("Expected bundle never reached the lanes by time %0t", $time);
                errors++;
            end
            @(negedge clk_i);
        end

        // Drain with every lane accepted
        fetch_valid_i    = 1'b0;
        branch_request_i = 1'b0;
        lane_accept_i    = 4'hf;
        waited           = 0;
        while ((exp_q.size() != 0 || lane_valid_o != 4'b0) && waited < DRAIN_LIMIT)
        begin
            score_edge();
            @(negedge clk_i);
            waited++;
        end
        if (waited >= DRAIN_LIMIT)
        begin
            $display("Timeout while draining, %0d bundles still expected", exp_q.size());
            errors++;
        end

        $display("Errors %0d, bundles %0d, lanes checked %0d, flushes %0d",
                 errors, bundles_in, lanes_checked, flushes);
        if (errors == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: fe_decode.f
+incdir+logic
+incdir+dv
logic/fe_decode_pkg.sv
logic/bundle_if.sv
logic/fetch_capture.sv
logic/lane_decoder.sv
logic/bundle_decode.sv
logic/issue_queue.sv
logic/fe_decode.sv
dv/fe_decode_tb.sv
